//--- mpls_egress_pkg.sv
////////////////////////////////////////////////////////////////////////////
// MPLS egress shared types
////////////////////////////////////////////////////////////////////////////

package mpls_egress_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths

    // Bytes carried by one input word from the forwarding engine
    localparam int egr_data_bytes = 8;

    typedef logic [egr_data_bytes*8-1:0] egr_word_t;

    // Bit 0 is the first byte on the wire, always contiguous from bit 0
    typedef logic [egr_data_bytes-1:0] egr_keep_t;

    typedef logic [7:0] egr_byte_t;

    // Wishbone data and counter width
    typedef logic [31:0] wb_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // State and register encodings

    typedef enum logic {
        IDLE    = 1'b0,
        FORWARD = 1'b1
    } demux_state_e;

    typedef enum logic {
        STORE   = 1'b0,
        DISCARD = 1'b1
    } buf_wr_state_e;

    // Low address bit of a counter register
    typedef enum logic {
        REG_DELIVERED = 1'b0,
        REG_DROPPED   = 1'b1
    } cnt_reg_e;

endpackage

//--- egress_word_if.sv
////////////////////////////////////////////////////////////////////////////
// Egress word link
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

// One stored word from the demultiplexer to a port buffer.
// No back-pressure, a word is taken on every cycle that valid is high
interface egress_word_if;

    import mpls_egress_pkg::*;

    logic      valid;
    egr_word_t data;
    egr_keep_t keep;
    logic      last;

    // Demultiplexer side
    modport src (
        output valid,
        output data,
        output keep,
        output last
    );

    // Port buffer side
    modport dst (
        input valid,
        input data,
        input keep,
        input last
    );

endinterface

//--- egress_demux.sv
////////////////////////////////////////////////////////////////////////////
// Egress port demultiplexer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_demux #(
    parameter int num_ports = 4
) (
    input  logic                            clk_ifc,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  mpls_egress_pkg::egr_word_t      in_data,
    input  mpls_egress_pkg::egr_keep_t      in_keep,
    input  logic                            in_last,
    input  logic [$clog2(num_ports)-1:0]    in_port,
    egress_word_if.src                      port_words [num_ports]
);

    import mpls_egress_pkg::*;

    localparam int port_w = $clog2(num_ports);

    demux_state_e      state;
    logic [port_w-1:0] port_q;

    // Registered copy of the input word
    logic      word_valid;
    egr_word_t word_data;
    egr_keep_t word_keep;
    logic      word_last;

    ////////////////////////////////////////////////////////////////////////////
    // Packet tracking

    // port_q is loaded on the edge that registers a first word, so it always
    // names the destination of the word currently held in the register
    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            state      <= IDLE;
            port_q     <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= in_valid;
            if (in_valid) begin
                case (state)
                    IDLE: begin
                        port_q <= in_port;
                        // Single word packets stay in IDLE
                        if (!in_last) begin
                            state <= FORWARD;
                        end
                    end
                    FORWARD: begin
                        if (in_last) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (in_valid) begin
            word_data <= in_data;
            word_keep <= in_keep;
            word_last <= in_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Steering

    // Payload is shared, only the addressed port sees valid
    for (genvar i = 0; i < num_ports; i++) begin : g_port
        assign port_words[i].valid = word_valid && (port_q == port_w'(i));
        assign port_words[i].data  = word_data;
        assign port_words[i].keep  = word_keep;
        assign port_words[i].last  = word_last;
    end

endmodule

//--- egress_port_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Egress port packet buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_port_buffer #(
    parameter int fifo_depth_words = 64
) (
    input  logic                        clk_ifc,
    input  logic                        rst_n,
    egress_word_if.dst                  word_in,
    input  logic                        out_ready,
    output mpls_egress_pkg::egr_byte_t  out_data,
    output logic                        out_valid,
    output logic                        out_last,
    output logic                        pkt_delivered,
    output logic                        pkt_dropped
);

    import mpls_egress_pkg::*;

    localparam int addr_w = $clog2(fifo_depth_words);

    // One extra bit tells a full buffer from an empty one
    typedef logic [addr_w:0] ptr_t;

    typedef struct packed {
        logic      last;
        egr_keep_t keep;
        egr_word_t data;
    } entry_t;

    entry_t mem [fifo_depth_words];

    // Write side
    buf_wr_state_e wr_state;
    ptr_t          wr_spec;
    ptr_t          wr_commit;
    ptr_t          held;
    logic          full;
    logic          wr_en;

    // Read side
    ptr_t      rd_ptr;
    logic      fetch_en;
    logic      fetch_valid;
    entry_t    fetch_q;
    logic      sh_valid;
    egr_word_t sh_data;
    egr_keep_t sh_keep;
    logic      sh_last;
    logic      sh_take;
    logic      sh_at_end;
    logic      sh_load;

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    // Words held count both committed and in-flight words not yet fetched
    assign held  = wr_spec - rd_ptr;
    assign full  = (held == ptr_t'(fifo_depth_words));
    assign wr_en = word_in.valid && (wr_state == STORE) && !full;

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wr_state    <= STORE;
            wr_spec     <= '0;
            wr_commit   <= '0;
            pkt_dropped <= 1'b0;
        end else begin
            pkt_dropped <= 1'b0;
            if (word_in.valid) begin
                case (wr_state)
                    STORE: begin
                        if (full) begin
                            // Abandon the packet and fall back to the last complete one
                            wr_spec     <= wr_commit;
                            pkt_dropped <= 1'b1;
                            if (!word_in.last) begin
                                wr_state <= DISCARD;
                            end
                        end else begin
                            wr_spec <= wr_spec + 1'b1;
                            if (word_in.last) begin
                                wr_commit <= wr_spec + 1'b1;
                            end
                        end
                    end
                    DISCARD: begin
                        // Skip the rest of the dropped packet
                        if (word_in.last) begin
                            wr_state <= STORE;
                        end
                    end
                    default: wr_state <= STORE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            mem[wr_spec[addr_w-1:0]] <= {word_in.last, word_in.keep, word_in.data};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side

    // Two stages: a fetch register after the RAM, then the byte shifter
    assign sh_take   = sh_valid && out_ready;
    assign sh_at_end = !sh_keep[1];
    assign sh_load   = fetch_valid && (!sh_valid || (sh_take && sh_at_end));
    assign fetch_en  = (rd_ptr != wr_commit) && (!fetch_valid || sh_load);

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            rd_ptr      <= '0;
            fetch_valid <= 1'b0;
            sh_valid    <= 1'b0;
        end else begin
            if (fetch_en) begin
                rd_ptr      <= rd_ptr + 1'b1;
                fetch_valid <= 1'b1;
            end else if (sh_load) begin
                fetch_valid <= 1'b0;
            end

            if (sh_load) begin
                sh_valid <= 1'b1;
            end else if (sh_take && sh_at_end) begin
                sh_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (fetch_en) begin
            fetch_q <= mem[rd_ptr[addr_w-1:0]];
        end
        // Lowest byte goes out first, keep shifts with it to mark the end
        if (sh_load) begin
            sh_data <= fetch_q.data;
            sh_keep <= fetch_q.keep;
            sh_last <= fetch_q.last;
        end else if (sh_take) begin
            sh_data <= sh_data >> $bits(egr_byte_t);
            sh_keep <= sh_keep >> 1;
        end
    end

    assign out_data      = sh_data[$bits(egr_byte_t)-1:0];
    assign out_valid     = sh_valid;
    assign out_last      = sh_valid && sh_last && sh_at_end;
    assign pkt_delivered = sh_take && out_last;

endmodule

//--- egress_pkt_counters.sv
////////////////////////////////////////////////////////////////////////////
// Egress packet counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_pkt_counters #(
    parameter int num_ports = 4
) (
    input  logic                        clk_ifc,
    input  logic                        rst_n,
    input  logic [num_ports-1:0]        pkt_delivered,
    input  logic [num_ports-1:0]        pkt_dropped,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [$clog2(num_ports):0]  wb_adr,
    input  mpls_egress_pkg::wb_data_t   wb_dat_w,
    output mpls_egress_pkg::wb_data_t   wb_dat_r,
    output logic                        wb_ack
);

    import mpls_egress_pkg::*;

    localparam int port_w = $clog2(num_ports);

    wb_data_t cnt_delivered [num_ports];
    wb_data_t cnt_dropped   [num_ports];

    logic                 req;
    logic [port_w-1:0]    req_port;
    cnt_reg_e             req_reg;
    wb_data_t             rd_val;
    logic [num_ports-1:0] clr_delivered;
    logic [num_ports-1:0] clr_dropped;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode

    // New request only while no ack is pending, giving one ack per cycle
    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign req_port = wb_adr[port_w:1];
    assign req_reg  = cnt_reg_e'(wb_adr[0]);

    // Out of range ports fall through to zero
    always_comb begin
        rd_val        = '0;
        clr_delivered = '0;
        clr_dropped   = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (req_port == port_w'(i)) begin
                rd_val = (req_reg == REG_DELIVERED) ? cnt_delivered[i] : cnt_dropped[i];
                // Write data is ignored, any write clears the counter
                clr_delivered[i] = req && wb_we && (req_reg == REG_DELIVERED);
                clr_dropped[i]   = req && wb_we && (req_reg == REG_DROPPED);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Counters

    // Clear wins over a pulse in the same cycle
    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ports; i++) begin
                cnt_delivered[i] <= '0;
                cnt_dropped[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < num_ports; i++) begin
                if (clr_delivered[i]) begin
                    cnt_delivered[i] <= '0;
                end else if (pkt_delivered[i]) begin
                    cnt_delivered[i] <= cnt_delivered[i] + 1'b1;
                end

                if (clr_dropped[i]) begin
                    cnt_dropped[i] <= '0;
                end else if (pkt_dropped[i]) begin
                    cnt_dropped[i] <= cnt_dropped[i] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone response

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_val;
        end
    end

endmodule

//--- mpls_egress.sv
////////////////////////////////////////////////////////////////////////////
// MPLS egress stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpls_egress #(
    parameter int num_ports        = 4,
    parameter int fifo_depth_words = 64
) (
    input  logic                                        clk_ifc,
    input  logic                                        rst_n,

    // Packet stream from the forwarding engine
    input  logic                                        in_valid,
    input  mpls_egress_pkg::egr_word_t                  in_data,
    input  mpls_egress_pkg::egr_keep_t                  in_keep,
    input  logic                                        in_last,
    input  logic [$clog2(num_ports)-1:0]                in_port,

    // Byte wide egress ports
    output mpls_egress_pkg::egr_byte_t [num_ports-1:0]  out_data,
    output logic [num_ports-1:0]                        out_valid,
    output logic [num_ports-1:0]                        out_last,
    input  logic [num_ports-1:0]                        out_ready,

    // Counter registers
    input  logic                                        wb_cyc,
    input  logic                                        wb_stb,
    input  logic                                        wb_we,
    input  logic [$clog2(num_ports):0]                  wb_adr,
    input  mpls_egress_pkg::wb_data_t                   wb_dat_w,
    output mpls_egress_pkg::wb_data_t                   wb_dat_r,
    output logic                                        wb_ack
);

    logic [num_ports-1:0] pkt_delivered;
    logic [num_ports-1:0] pkt_dropped;

    egress_word_if port_words [num_ports] ();

    egress_demux #(
        .num_ports  (num_ports)
    ) u_demux (
        .clk_ifc    (clk_ifc),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_last    (in_last),
        .in_port    (in_port),
        .port_words (port_words)
    );

    // One packet buffer per egress port
    for (genvar i = 0; i < num_ports; i++) begin : g_port
        egress_port_buffer #(
            .fifo_depth_words (fifo_depth_words)
        ) u_buffer (
            .clk_ifc       (clk_ifc),
            .rst_n         (rst_n),
            .word_in       (port_words[i]),
            .out_ready     (out_ready[i]),
            .out_data      (out_data[i]),
            .out_valid     (out_valid[i]),
            .out_last      (out_last[i]),
            .pkt_delivered (pkt_delivered[i]),
            .pkt_dropped   (pkt_dropped[i])
        );
    end

    egress_pkt_counters #(
        .num_ports     (num_ports)
    ) u_counters (
        .clk_ifc       (clk_ifc),
        .rst_n         (rst_n),
        .pkt_delivered (pkt_delivered),
        .pkt_dropped   (pkt_dropped),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack)
    );

endmodule

//--- tb_mpls_egress.sv
////////////////////////////////////////////////////////////////////////////
// MPLS egress testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mpls_egress;

    import mpls_egress_pkg::*;

    logic            clk_ifc;
    logic            rst_n;
    logic            in_valid;
    egr_word_t       in_data;
    egr_keep_t       in_keep;
    logic            in_last;
    logic [1:0]      in_port;
    logic [3:0][7:0] out_data;
    logic [3:0]      out_valid;
    logic [3:0]      out_last;
    logic [3:0]      out_ready;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [2:0]      wb_adr;
    wb_data_t        wb_dat_w;
    wb_data_t        wb_dat_r;
    logic            wb_ack;

    // Expected packet lengths per port, oldest first
    int          exp_len [4][$];
    int          rx_bytes [4];
    int          rx_count [4];
    logic        prev_valid [4];
    logic        prev_ready [4];
    logic [7:0]  prev_data [4];
    int          ack_pulses;
    logic [31:0] stim_rng;
    logic [31:0] ready_rng;
    int          low_run [4];
    logic [3:0]  hold_low;
    logic        random_ready;
    int          edge_lens [6] = '{1, 7, 8, 9, 255, 256};

    mpls_egress #(
        .num_ports        (4),
        .fifo_depth_words (64)
    ) uut (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_port   (in_port),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    always #2 clk_ifc = ~clk_ifc;

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic require(input bit cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        stim_rng = xorshift32(stim_rng);
        return lo + int'(stim_rng % 32'(hi - lo + 1));
    endfunction

    // Words of every packet sent to a port and not yet fully received
    function automatic int queued_words(input int p);
        int total;
        total = 0;
        for (int k = 0; k < exp_len[p].size(); k++) begin
            total += (exp_len[p][k] + 7) / 8;
        end
        return total;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks

    // Leaves the last word on the bus so the next packet can follow directly
    task automatic send_packet(input int port, input int len, input bit expect_rx);
        int        words;
        int        rem;
        egr_word_t data;
        words = (len + 7) / 8;
        if (expect_rx) begin
            exp_len[port].push_back(len);
        end
        for (int w = 0; w < words; w++) begin
            for (int b = 0; b < 8; b++) begin
                data[b*8 +: 8] = 8'((w * 8 + b) % 256);
            end
            rem = len - w * 8;
            @(posedge clk_ifc);
            in_valid <= 1'b1;
            in_port  <= 2'(port);
            in_data  <= data;
            in_keep  <= (rem >= 8) ? 8'hff : (8'hff >> (8 - rem));
            in_last  <= (w == words - 1);
        end
    endtask

    task automatic end_input();
        @(posedge clk_ifc);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
    endtask

    // Keeps the port below a full buffer, so no drop is allowed to happen
    task automatic wait_for_room(input int port, input int words);
        int cycles;
        cycles = 0;
        while (queued_words(port) + words > 64) begin
            @(posedge clk_ifc);
            in_valid <= 1'b0;
            in_last  <= 1'b0;
            cycles++;
            if (cycles > 20000) begin
                $display("timeout: port %0d never made room for a packet", port);
                abort_run();
            end
        end
    endtask

    task automatic wait_drained(input int port);
        int cycles;
        cycles = 0;
        while (exp_len[port].size() != 0) begin
            @(posedge clk_ifc);
            cycles++;
            if (cycles > 20000) begin
                $display("timeout: port %0d did not deliver all its packets", port);
                abort_run();
            end
        end
    endtask

    // One Wishbone cycle, returns the read data seen during ack
    task automatic bus_cycle(input int port, input cnt_reg_e sel, input bit write,
                             output logic [31:0] rdata);
        int cycles;
        int acks_before;
        acks_before = ack_pulses;
        @(posedge clk_ifc);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= write;
        wb_adr   <= {2'(port), sel};
        wb_dat_w <= 32'h5a5a_0f0f;
        cycles = 0;
        @(posedge clk_ifc);
        while (!wb_ack) begin
            cycles++;
            if (cycles > 20) begin
                $display("timeout: no Wishbone ack for port %0d", port);
                abort_run();
            end
            @(posedge clk_ifc);
        end
        rdata  = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        repeat (2) @(posedge clk_ifc);
        expect_equal("wb_ack pulse count", 32'(acks_before + 1), 32'(ack_pulses));
    endtask

    task automatic read_counter(input int port, input cnt_reg_e sel, input int expected);
        logic [31:0] rdata;
        bus_cycle(port, sel, 1'b0, rdata);
        expect_equal($sformatf("wb_dat_r port %0d reg %0d", port, sel), 32'(expected), rdata);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output side

    // Random back-pressure with low runs of at most three cycles
    always @(posedge clk_ifc) begin
        for (int i = 0; i < 4; i++) begin
            ready_rng = xorshift32(ready_rng);
            if (hold_low[i]) begin
                out_ready[i] <= 1'b0;
            end else if (random_ready && ready_rng[1:0] == 2'b00 && low_run[i] < 3) begin
                out_ready[i] <= 1'b0;
                low_run[i]++;
            end else begin
                out_ready[i] <= 1'b1;
                low_run[i] = 0;
            end
        end
    end

    always @(posedge clk_ifc) begin
        if (wb_ack) begin
            ack_pulses++;
        end
    end

    // Byte sinks, one per port
    always @(posedge clk_ifc) begin
        if (rst_n) begin
            for (int i = 0; i < 4; i++) begin
                // A stalled byte stays put until it is taken
                if (prev_valid[i] && !prev_ready[i]) begin
                    require(out_valid[i] === 1'b1,
                            $sformatf("port %0d withdrew out_valid before transfer", i));
                    expect_equal($sformatf("out_data[%0d] while stalled", i),
                                 32'(prev_data[i]), 32'(out_data[i]));
                end
                if (out_valid[i] && out_ready[i]) begin
                    expect_equal($sformatf("out_data[%0d]", i),
                                 32'(rx_bytes[i] % 256), 32'(out_data[i]));
                    rx_bytes[i]++;
                    if (out_last[i]) begin
                        require(exp_len[i].size() > 0,
                                $sformatf("port %0d delivered a packet never sent to it", i));
                        expect_equal($sformatf("port %0d packet length", i),
                                     32'(exp_len[i][0]), 32'(rx_bytes[i]));
                        void'(exp_len[i].pop_front());
                        rx_bytes[i] = 0;
                        rx_count[i]++;
                    end
                end
                prev_valid[i] = out_valid[i];
                prev_ready[i] = out_ready[i];
                prev_data[i]  = out_data[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int          len;
        int          port;
        logic [31:0] write_rdata;
        clk_ifc      = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_keep      = '0;
        in_last      = 1'b0;
        in_port      = '0;
        out_ready    = '1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        hold_low     = '0;
        random_ready = 1'b0;
        stim_rng     = 32'he078;
        ready_rng    = 32'he078;
        ack_pulses   = 0;
        for (int i = 0; i < 4; i++) begin
            rx_bytes[i]   = 0;
            rx_count[i]   = 0;
            low_run[i]    = 0;
            prev_valid[i] = 1'b0;
            prev_ready[i] = 1'b0;
            prev_data[i]  = '0;
        end

        repeat (10) @(posedge clk_ifc);
        rst_n <= 1'b1;
        @(posedge clk_ifc);
        require(out_valid === 4'b0 && out_last === 4'b0 && wb_ack === 1'b0,
                "outputs are not idle after reset");

        // Routing, one packet at a time, edge lengths first
        for (int n = 0; n < 40; n++) begin
            len = (n < 6) ? edge_lens[n] : rand_range(1, 256);
            send_packet(n % 4, len, 1'b1);
            end_input();
            wait_drained(n % 4);
        end

        // Back to back traffic under random back-pressure
        random_ready <= 1'b1;
        for (int n = 0; n < 48; n++) begin
            port = rand_range(0, 3);
            len  = rand_range(1, 256);
            wait_for_room(port, (len + 7) / 8);
            send_packet(port, len, 1'b1);
        end
        end_input();
        for (int i = 0; i < 4; i++) begin
            wait_drained(i);
        end
        random_ready <= 1'b0;

        // Overflow on port 2, two packets fit and four are dropped
        hold_low <= 4'b0100;
        repeat (4) @(posedge clk_ifc);
        for (int n = 0; n < 6; n++) begin
            send_packet(2, 256, n < 2);
            len = rand_range(1, 64);
            wait_for_room(0, (len + 7) / 8);
            send_packet(0, len, 1'b1);
        end
        end_input();
        wait_drained(0);
        // First stored packet waits at the port output
        expect_equal("out_valid[2] while held", 32'd1, 32'(out_valid[2]));
        hold_low <= 4'b0000;
        wait_drained(2);
        repeat (100) @(posedge clk_ifc);
        expect_equal("out_valid[2] after release", 32'd0, 32'(out_valid[2]));
        for (int n = 0; n < 20; n++) begin
            len = rand_range(1, 256);
            wait_for_room(2, (len + 7) / 8);
            send_packet(2, len, 1'b1);
        end
        end_input();
        wait_drained(2);

        // Counter registers
        repeat (10) @(posedge clk_ifc);
        for (int i = 0; i < 4; i++) begin
            read_counter(i, REG_DELIVERED, rx_count[i]);
            read_counter(i, REG_DROPPED, (i == 2) ? 4 : 0);
        end
        bus_cycle(1, REG_DELIVERED, 1'b1, write_rdata);
        read_counter(1, REG_DELIVERED, 0);
        bus_cycle(2, REG_DROPPED, 1'b1, write_rdata);
        read_counter(2, REG_DROPPED, 0);
        read_counter(3, REG_DELIVERED, rx_count[3]);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- mpls_egress.f
mpls_egress_pkg.sv
egress_word_if.sv
egress_demux.sv
egress_port_buffer.sv
egress_pkt_counters.sv
mpls_egress.sv
tb_mpls_egress.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MPLS egress testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_mpls_egress
log_file=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_mpls_egress \
    --Mdir "$build_dir" -o "$sim_bin" \
    -f mpls_egress.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1
